// ==== hw/frame_cfg.svh ====
`ifndef FRAME_CFG_SVH
`define FRAME_CFG_SVH

// image geometry
`define FRAME_WIDTH 16
`define FRAME_HEIGHT 8
`define FRAME_PIXELS 128

// index and counter widths
`define FRAME_X_BITS 4
`define FRAME_Y_BITS 3
`define FRAME_ADDR_BITS 7
`define FRAME_COUNT_BITS 8 // must hold FRAME_PIXELS itself

`endif

// ==== hw/frame_pkg.sv ====
`include "frame_cfg.svh"

package frame_pkg;

    // capture sequence of the frame store
    typedef enum logic [1:0] {
        cap_idle      = 2'd0,
        cap_capturing = 2'd1,
        cap_complete  = 2'd2
    } capture_state_t;

    typedef logic [`FRAME_X_BITS-1:0] pix_x_t; // column index
    typedef logic [`FRAME_Y_BITS-1:0] pix_y_t; // row index
    typedef logic [`FRAME_ADDR_BITS-1:0] pix_addr_t; // row * width + column
    typedef logic [`FRAME_COUNT_BITS-1:0] pix_count_t; // foreground pixel count

endpackage

// ==== hw/pixel_threshold.sv ====
`timescale 1ns/1ps

module pixel_threshold (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pix_valid,
    output logic       pix_ready,
    input  logic [7:0] pix_data,
    input  logic [7:0] threshold,
    output logic       bin_valid,
    input  logic       bin_ready,
    output logic [7:0] bin_data
);

    logic accept;

    // stage is free when empty or when its word leaves this cycle
    assign pix_ready = !bin_valid || bin_ready;
    assign accept = pix_valid && pix_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bin_valid <= 1'b0;
        end else if (accept) begin
            bin_valid <= 1'b1;
        end else if (bin_ready) begin
            bin_valid <= 1'b0; // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bin_data <= (pix_data >= threshold) ? 8'd255 : 8'd0;
        end
    end

    // a stalled output word must not change under the consumer
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bin_valid && !bin_ready) |=> $stable(bin_data));

endmodule

// ==== hw/binary_bram.sv ====
`timescale 1ns/1ps
`include "frame_cfg.svh"

module binary_bram #(
    parameter int pixel_count = `FRAME_PIXELS
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                x_valid,
    output logic                x_ready,
    input  logic [7:0]          x_data,
    input  frame_pkg::pix_addr_t read_addr,
    output logic                read_data,
    input  logic                capture_trigger,
    output logic                valid_to_read,
    output logic                capture_complete,
    output logic                capturing
);

    import frame_pkg::*;

    localparam int addr_w = (pixel_count > 1) ? $clog2(pixel_count) : 1;

    capture_state_t    state;
    logic [addr_w-1:0] write_addr;
    logic              handshake;
    logic              mem [0:pixel_count-1]; // one bit per pixel

    assign x_ready = (state == cap_capturing);
    assign handshake = x_valid && x_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cap_idle;
            write_addr <= '0;
            capturing <= 1'b0;
            capture_complete <= 1'b0;
            valid_to_read <= 1'b0;
        end else begin
            capture_complete <= 1'b0;
            case (state)
                cap_idle: begin
                    if (capture_trigger) begin
                        state <= cap_capturing;
                        capturing <= 1'b1;
                        write_addr <= '0;
                        valid_to_read <= 1'b0; // old frame is overwritten from now on
                    end
                end
                cap_capturing: begin
                    if (handshake) begin
                        if (write_addr == addr_w'(pixel_count - 1)) begin
                            state <= cap_complete;
                        end else begin
                            write_addr <= write_addr + 1'b1;
                        end
                    end
                end
                cap_complete: begin
                    state <= cap_idle; // trigger in this cycle is dropped
                    capturing <= 1'b0;
                    capture_complete <= 1'b1;
                    valid_to_read <= 1'b1;
                end
                default: state <= cap_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (handshake) begin
            mem[write_addr] <= (x_data == 8'd255);
        end
    end

    // registered read, frozen until a frame is stored
    always_ff @(posedge clk) begin
        if (valid_to_read) begin
            read_data <= mem[read_addr];
        end
    end

    a_ready_in_capture: assert property (@(posedge clk) disable iff (!rst_n)
        x_ready |-> capturing);

    a_complete_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        capture_complete |=> !capture_complete);

    a_read_range: assert property (@(posedge clk) disable iff (!rst_n)
        read_addr < pixel_count);

endmodule

// ==== hw/frame_scanner.sv ====
`timescale 1ns/1ps
`include "frame_cfg.svh"

module frame_scanner (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  capture_complete,
    output frame_pkg::pix_addr_t  read_addr,
    input  logic                  read_data,
    output logic                  scan_busy,
    output logic                  scan_done,
    output frame_pkg::pix_count_t fg_count,
    output frame_pkg::pix_x_t     min_x,
    output frame_pkg::pix_x_t     max_x,
    output frame_pkg::pix_y_t     min_y,
    output frame_pkg::pix_y_t     max_y,
    output logic                  box_found
);

    import frame_pkg::*;

    pix_x_t col;
    pix_y_t row;
    pix_x_t col_d; // coordinates of the bit now on read_data
    pix_y_t row_d;
    logic   issuing;
    logic   data_valid;
    logic   data_last;
    logic   last_addr;

    assign read_addr = pix_addr_t'(row * `FRAME_WIDTH + col);
    assign last_addr = (col == pix_x_t'(`FRAME_WIDTH - 1)) &&
                       (row == pix_y_t'(`FRAME_HEIGHT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
            issuing <= 1'b0;
            data_valid <= 1'b0;
            data_last <= 1'b0;
            scan_busy <= 1'b0;
            scan_done <= 1'b0;
            fg_count <= '0;
            min_x <= '0;
            max_x <= '0;
            min_y <= '0;
            max_y <= '0;
            box_found <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            data_valid <= issuing; // bram samples the address on this edge
            data_last <= issuing && last_addr;
            if (capture_complete) begin
                scan_busy <= 1'b1;
                issuing <= 1'b1;
                col <= '0;
                row <= '0;
                fg_count <= '0;
                min_x <= '0;
                max_x <= '0;
                min_y <= '0;
                max_y <= '0;
                box_found <= 1'b0;
            end else begin
                if (issuing) begin
                    if (last_addr) begin
                        issuing <= 1'b0;
                    end else if (col == pix_x_t'(`FRAME_WIDTH - 1)) begin
                        col <= '0;
                        row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                if (data_valid && read_data) begin
                    fg_count <= fg_count + 1'b1;
                    // first hit seeds the box
                    if (!box_found || col_d < min_x) min_x <= col_d;
                    if (!box_found || col_d > max_x) max_x <= col_d;
                    if (!box_found || row_d < min_y) min_y <= row_d;
                    if (!box_found || row_d > max_y) max_y <= row_d;
                    box_found <= 1'b1;
                end
                if (data_valid && data_last) begin
                    scan_done <= 1'b1; // last bit lands in the same edge
                    scan_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        col_d <= col;
        row_d <= row;
    end

    // a new frame must not be announced while the old one is still swept
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        capture_complete |-> !scan_busy);

endmodule

// ==== hw/frame_grabber_top.sv ====
`timescale 1ns/1ps

module frame_grabber_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_valid,
    output logic                  pix_ready,
    input  logic [7:0]            pix_data,
    input  logic [7:0]            threshold,
    input  logic                  capture_trigger,
    output logic                  capturing,
    output logic                  capture_complete,
    output logic                  scan_done,
    output frame_pkg::pix_count_t fg_count,
    output frame_pkg::pix_x_t     min_x,
    output frame_pkg::pix_x_t     max_x,
    output frame_pkg::pix_y_t     min_y,
    output frame_pkg::pix_y_t     max_y,
    output logic                  box_found
);

    import frame_pkg::*;

    logic       bin_valid;
    logic       bin_ready;
    logic [7:0] bin_data;
    pix_addr_t  read_addr;
    logic       read_data;

    pixel_threshold pixel_threshold_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .threshold (threshold),
        .bin_valid (bin_valid),
        .bin_ready (bin_ready),
        .bin_data  (bin_data)
    );

    binary_bram binary_bram_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .x_valid          (bin_valid),
        .x_ready          (bin_ready),
        .x_data           (bin_data),
        .read_addr        (read_addr),
        .read_data        (read_data),
        .capture_trigger  (capture_trigger),
        .valid_to_read    (),
        .capture_complete (capture_complete),
        .capturing        (capturing)
    );

    frame_scanner frame_scanner_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .capture_complete (capture_complete),
        .read_addr        (read_addr),
        .read_data        (read_data),
        .scan_busy        (),
        .scan_done        (scan_done),
        .fg_count         (fg_count),
        .min_x            (min_x),
        .max_x            (max_x),
        .min_y            (min_y),
        .max_y            (max_y),
        .box_found        (box_found)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1; // release away from the edge
    end

endmodule

// ==== testbench/frame_grabber_checker.sv ====
`timescale 1ns/1ps
`include "frame_cfg.svh"

module frame_grabber_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_valid,
    input  logic                  pix_ready,
    input  logic [7:0]            pix_data,
    input  logic [7:0]            threshold,
    input  logic                  capture_trigger,
    input  logic                  capturing,
    input  logic                  capture_complete,
    input  logic                  scan_done,
    input  frame_pkg::pix_count_t fg_count,
    input  frame_pkg::pix_x_t     min_x,
    input  frame_pkg::pix_x_t     max_x,
    input  frame_pkg::pix_y_t     min_y,
    input  frame_pkg::pix_y_t     max_y,
    input  logic                  box_found,
    output int                    error_count,
    output int                    frames_checked
);

    import frame_pkg::*;

    int             taken;          // pixels accepted in this frame
    int             exp_count;
    int             exp_box [4];    // min_x, max_x, min_y, max_y
    int             since_complete;
    int             pulses;
    logic           capturing_d;
    logic           trigger_d;
    capture_state_t phase;          // capture state as seen from the ports

    task automatic compare(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s (capture %s)", $time, what, phase.name());
        error_count++;
    endtask

    task automatic start_frame();
        taken = 0;
        exp_count = 0;
        pulses = 0;
        exp_box = '{`FRAME_WIDTH, -1, `FRAME_HEIGHT, -1}; // empty box
    endtask

    initial begin
        error_count = 0;
        frames_checked = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            if (capturing || capture_complete || scan_done) begin
                report_failure("status outputs are not low during reset");
            end
            start_frame();
            since_complete = 0;
            capturing_d = 1'b0;
            trigger_d = 1'b0;
            phase = cap_idle;
        end else begin
            since_complete++;
            if (pix_valid && pix_ready && !capturing && taken > 0) begin
                report_failure("a second pixel was accepted before the trigger");
            end
            if (pix_valid && pix_ready) begin
                if (pix_data >= threshold) begin // foreground by the threshold rule
                    exp_count++;
                    if (taken % `FRAME_WIDTH < exp_box[0]) exp_box[0] = taken % `FRAME_WIDTH;
                    if (taken % `FRAME_WIDTH > exp_box[1]) exp_box[1] = taken % `FRAME_WIDTH;
                    if (taken / `FRAME_WIDTH < exp_box[2]) exp_box[2] = taken / `FRAME_WIDTH;
                    if (taken / `FRAME_WIDTH > exp_box[3]) exp_box[3] = taken / `FRAME_WIDTH;
                end
                taken++;
            end
            if (capturing && !capturing_d) begin
                if (!trigger_d) report_failure("capturing rose without a trigger");
                phase = cap_capturing;
            end
            if ((capturing_d && !capturing) != capture_complete) begin
                report_failure("capture_complete does not match the end of capturing");
            end
            if (capture_complete) begin
                compare("pixels taken at end of capture", taken, `FRAME_PIXELS);
                pulses++;
                since_complete = 0;
                phase = cap_complete;
            end
            if (scan_done) begin
                compare("cycles from capture_complete to scan_done", since_complete,
                        `FRAME_PIXELS + 2);
                compare("capture_complete pulses", pulses, 1);
                compare("fg_count", int'(fg_count), exp_count);
                compare("box_found", int'(box_found), int'(exp_count > 0));
                compare("min_x", int'(min_x), (exp_count > 0) ? exp_box[0] : 0);
                compare("max_x", int'(max_x), (exp_count > 0) ? exp_box[1] : 0);
                compare("min_y", int'(min_y), (exp_count > 0) ? exp_box[2] : 0);
                compare("max_y", int'(max_y), (exp_count > 0) ? exp_box[3] : 0);
                frames_checked++;
                start_frame();
                phase = cap_idle;
            end
            capturing_d = capturing;
            trigger_d = capture_trigger;
        end
    end

endmodule

// ==== testbench/frame_grabber_tb.sv ====
`timescale 1ns/1ps
`include "frame_cfg.svh"

module frame_grabber_tb;

    import frame_pkg::*;

    localparam int num_cases  = 8;
    localparam int timeout_ns = num_cases * (`FRAME_PIXELS * 3 + 50) * 4;
    localparam int pat_random = 0;
    localparam int pat_dark   = 1;
    localparam int pat_bright = 2;
    localparam int pat_rect   = 3;

    typedef struct {
        int threshold;
        int kind;
        int x0;
        int y0;
        int x1;
        int y1;
        int gap_pct; // chance of an idle cycle before a pixel
    } frame_case_t;

    logic        clk;
    logic        rst_n;
    logic        pix_valid;
    logic        pix_ready;
    logic [7:0]  pix_data;
    logic [7:0]  threshold;
    logic        capture_trigger;
    logic        capturing;
    logic        capture_complete;
    logic        scan_done;
    pix_count_t  fg_count;
    pix_x_t      min_x;
    pix_x_t      max_x;
    pix_y_t      min_y;
    pix_y_t      max_y;
    logic        box_found;
    int          error_count;
    int          frames_checked;
    logic [31:0] lcg_state;
    frame_case_t cases [num_cases];

    tb_clock_gen clock_gen_inst (.clk(clk), .rst_n(rst_n));

    frame_grabber_top frame_grabber_top_inst (.*);

    frame_grabber_checker checker_inst (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] pixel_value(input frame_case_t fc, input int idx,
                                               input logic [7:0] rnd);
        int   px;
        int   py;
        logic in_rect;
        px = idx % `FRAME_WIDTH;
        py = idx / `FRAME_WIDTH;
        in_rect = (px >= fc.x0) && (px <= fc.x1) && (py >= fc.y0) && (py <= fc.y1);
        case (fc.kind)
            pat_dark:   return 8'd0;
            pat_bright: return 8'd255;
            pat_rect:   return {in_rect, rnd[6:0]}; // in_rect lands at or above 128
            default:    return rnd;
        endcase
    endfunction

    task automatic send_pixel(input logic [7:0] value);
        logic done;
        pix_valid = 1'b1;
        pix_data = value;
        done = 1'b0;
        while (!done) begin // held until the DUT takes it
            @(posedge clk);
            done = pix_ready;
            #1;
        end
        pix_valid = 1'b0;
    endtask

    task automatic run_frame(input frame_case_t fc);
        threshold = 8'(fc.threshold);
        fork
            begin
                for (int idx = 0; idx < `FRAME_PIXELS; idx++) begin
                    lcg_state = lcg_next(lcg_state);
                    if (int'(lcg_state[11:4]) % 100 < fc.gap_pct) begin
                        @(posedge clk);
                        #1;
                    end
                    send_pixel(pixel_value(fc, idx, lcg_state[23:16]));
                end
            end
            begin
                repeat (6) @(posedge clk); // source stalls until the trigger
                #1 capture_trigger = 1'b1;
                @(posedge clk);
                #1 capture_trigger = 1'b0;
            end
        join
        while (!scan_done) @(posedge clk);
        #1;
    endtask

    initial begin
        pix_valid = 1'b0;
        pix_data = 8'd0;
        threshold = 8'd0;
        capture_trigger = 1'b0;
        lcg_state = 32'd91510;
        cases[0] = '{128, pat_random, 0, 0, 0, 0, 0};
        cases[1] = '{60, pat_random, 0, 0, 0, 0, 30};
        cases[2] = '{220, pat_random, 0, 0, 0, 0, 10};
        cases[3] = '{100, pat_dark, 0, 0, 0, 0, 0};
        cases[4] = '{255, pat_bright, 0, 0, 0, 0, 20};
        cases[5] = '{128, pat_rect, 3, 2, 10, 5, 0};
        cases[6] = '{128, pat_rect, 0, 0, 0, 0, 25};
        cases[7] = '{128, pat_rect, 9, 1, 15, 7, 15};
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        for (int c = 0; c < num_cases; c++) begin
            run_frame(cases[c]);
        end
        repeat (4) @(posedge clk);
        $display("frames checked: %0d of %0d, errors: %0d", frames_checked, num_cases,
                 error_count);
        if (error_count == 0 && frames_checked == num_cases) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the frame cases did not finish within %0d ns", timeout_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/frame_pkg.sv
hw/pixel_threshold.sv
hw/binary_bram.sv
hw/frame_scanner.sv
hw/frame_grabber_top.sv
testbench/tb_clock_gen.sv
testbench/frame_grabber_checker.sv
testbench/frame_grabber_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame grabber testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module frame_grabber_tb \
    -f filelist.f -o frame_grabber_sim > build.log 2>&1 \
    && ./obj_dir/frame_grabber_sim > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
